//--- sources.f
afu_pkg.sv
sync_fifo.sv
command_arbiter.sv
credit_tracker.sv
tag_table.sv
response_router.sv
afu_control.sv
afu_control_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= afu_control_tb
FILELIST ?= sources.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps -j 0
SIM ?= $(OBJ_DIR)/V$(TOP)

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

//--- afu_control_tb.sv
`default_nettype none

module afu_control_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// Watchdog budget, every command bounded by the same cycle count
	localparam int NUM_CMDS = 177;
	localparam int CYCLES_PER_CMD = 20;
	localparam int TAG_IDX_W = $clog2(afu_pkg::NUM_TAGS);

	// Routed response the scoreboard waits for
	typedef struct packed {
		afu_pkg::cmd_class_t rsp_class;
		logic [afu_pkg::TAG_W-1:0] tag;
		logic [afu_pkg::CODE_W-1:0] response;
		int due;
	} expect_t;

	logic clock = 1'b0;
	logic rst_n;
	logic enabled;
	afu_pkg::cmd_line_t [afu_pkg::NUM_CLASSES-1:0] cmd_drive;
	afu_pkg::host_rsp_t host_rsp_in = '0;
	afu_pkg::host_cmd_t host_cmd_out;
	afu_pkg::rsp_line_t [afu_pkg::NUM_CLASSES-1:0] rsp_out;
	afu_pkg::cmd_status_t command_status;
	logic [afu_pkg::NUM_CLASSES-1:0] rsp_valids;

	// Scoreboard state
	afu_pkg::cmd_line_t queued[$];
	afu_pkg::cmd_class_t issue_log[$];
	logic [afu_pkg::TAG_W-1:0] pending[$];
	expect_t expected[$];
	afu_pkg::cmd_class_t tag_class [afu_pkg::NUM_TAGS];
	logic [afu_pkg::NUM_TAGS-1:0] tag_busy;
	int cycle;
	int credits;
	int refill_l1;
	int refill_l2;
	int seq;
	int host_gap = 0;
	logic hold_rsp;
	logic [31:0] stim_rng;
	logic [31:0] host_rng = 32'd96481;

	afu_control UUT (
		.clock(clock), .rst_n(rst_n), .enabled(enabled),
		.restart_cmd_in(cmd_drive[0]), .wed_cmd_in(cmd_drive[1]),
		.write_cmd_in(cmd_drive[2]), .read_cmd_in(cmd_drive[3]),
		.host_rsp_in(host_rsp_in), .host_cmd_out(host_cmd_out),
		.restart_rsp_out(rsp_out[0]), .wed_rsp_out(rsp_out[1]),
		.write_rsp_out(rsp_out[2]), .read_rsp_out(rsp_out[3]),
		.command_status(command_status)
	);

	always #20 clock = ~clock;

	always_comb begin
		for (int c = 0; c < afu_pkg::NUM_CLASSES; c++) begin
			rsp_valids[c] = rsp_out[c].valid;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	task automatic fail_with(input string line);
		$display("%s", line);
		$display("Result: FAILED");
		$fatal(1);
	endtask

	// Class sits in the top address bits, sequence below it
	function automatic afu_pkg::cmd_line_t make_line(input int cls, input int n);
		afu_pkg::cmd_line_t line;
		line.valid = 1'b1;
		line.code = afu_pkg::CODE_W'(n * 7 + cls);
		line.address = {afu_pkg::CLASS_W'(cls), (afu_pkg::ADDR_W - afu_pkg::CLASS_W)'(n)};
		line.size = afu_pkg::SIZE_W'(n * 64);
		return line;
	endfunction

	////////////////////////////////////////
	// Protocol assertions
	////////////////////////////////////////

	assert property (@(posedge clock) !rst_n |=> !host_cmd_out.valid && rsp_valids == '0
		&& command_status.empty == '1)
		else fail_with($sformatf("FAIL %0t outputs not idle after reset", $time));
	// Nothing issues unless enabled was seen at the issuing edge
	assert property (@(posedge clock) disable iff (!rst_n) host_cmd_out.valid |-> $past(enabled))
		else fail_with($sformatf("FAIL %0t issue while disabled", $time));
	assert property (@(posedge clock) disable iff (!rst_n) $onehot0(rsp_valids))
		else fail_with($sformatf("FAIL %0t several response outputs at once", $time));

	////////////////////////////////////////
	// Scoreboard
	////////////////////////////////////////

	always @(posedge clock) begin : scoreboard
		int idx;
		afu_pkg::cmd_class_t cls;
		if (!rst_n) begin
			cycle = 0;
			credits = afu_pkg::INIT_CREDITS;
			refill_l1 = 0;
			refill_l2 = 0;
			tag_busy = '0;
		end else begin
			cycle++;
			// Response due three cycles after its latch, on its own class only
			if (expected.size() > 0 && expected[0].due == cycle) begin
				cls = expected[0].rsp_class;
				assert (rsp_valids == (afu_pkg::NUM_CLASSES'(1) << cls)
					&& rsp_out[cls].rsp_class == cls && rsp_out[cls].tag == expected[0].tag
					&& rsp_out[cls].response == expected[0].response)
					else fail_with($sformatf("FAIL %0t tag %0d not routed to class %0d",
						$time, expected[0].tag, cls));
				void'(expected.pop_front());
			end else begin
				assert (rsp_valids == '0)
					else fail_with($sformatf("FAIL %0t unexpected response %b", $time, rsp_valids));
			end
			for (int c = 0; c < afu_pkg::NUM_CLASSES; c++) begin
				if (cmd_drive[c].valid) begin
					queued.push_back(cmd_drive[c]);
				end
			end
			if (host_cmd_out.valid) begin
				cls = afu_pkg::cmd_class_t'(host_cmd_out.address[afu_pkg::ADDR_W-1 -: afu_pkg::CLASS_W]);
				idx = -1;
				// Oldest queued line of that class
				for (int i = queued.size() - 1; i >= 0; i--) begin
					if (queued[i].address[afu_pkg::ADDR_W-1 -: afu_pkg::CLASS_W] == cls) begin
						idx = i;
					end
				end
				assert (idx >= 0 && queued[idx].address == host_cmd_out.address
					&& queued[idx].code == host_cmd_out.code && queued[idx].size == host_cmd_out.size)
					else fail_with($sformatf("FAIL %0t issue %h out of order", $time,
						host_cmd_out.address));
				assert (credits > 0)
					else fail_with($sformatf("FAIL %0t issue without credit", $time));
				assert (host_cmd_out.tag < afu_pkg::TAG_W'(afu_pkg::NUM_TAGS)
					&& !tag_busy[host_cmd_out.tag[TAG_IDX_W-1:0]]
					&& $countones(tag_busy) < afu_pkg::NUM_TAGS)
					else fail_with($sformatf("FAIL %0t tag %0d reused", $time, host_cmd_out.tag));
				tag_busy[host_cmd_out.tag[TAG_IDX_W-1:0]] = 1'b1;
				tag_class[host_cmd_out.tag[TAG_IDX_W-1:0]] = cls;
				issue_log.push_back(cls);
				queued.delete(idx);
			end
			// Spent at the issuing edge, refilled one edge after the latch
			credits = credits - int'(host_cmd_out.valid) + refill_l2;
			refill_l2 = refill_l1;
			refill_l1 = host_rsp_in.valid ? int'(host_rsp_in.credits) : 0;
			if (host_rsp_in.valid) begin
				tag_busy[host_rsp_in.tag[TAG_IDX_W-1:0]] = 1'b0;
				expected.push_back('{rsp_class: tag_class[host_rsp_in.tag[TAG_IDX_W-1:0]],
					tag: host_rsp_in.tag, response: host_rsp_in.response, due: cycle + 3});
			end
		end
	end

	// Host answers outstanding tags in random order, one credit each
	always @(posedge clock) begin : host_model
		int idx;
		host_rsp_in <= '0;
		if (rst_n && host_cmd_out.valid) begin
			pending.push_back(host_cmd_out.tag);
		end
		if (rst_n && !hold_rsp && pending.size() > 0) begin
			if (host_gap > 0) begin
				host_gap--;
			end else begin
				host_rng = xorshift(host_rng);
				idx = int'(host_rng[15:0]) % pending.size();
				host_rsp_in <= '{valid: 1'b1, tag: pending[idx], response: host_rng[23:16],
					credits: afu_pkg::CREDIT_W'(1)};
				pending.delete(idx);
				host_gap = int'(host_rng[25:24]);
			end
		end
	end

	task automatic push_lines(input logic [afu_pkg::NUM_CLASSES-1:0] mask);
		@(posedge clock);
		for (int c = 0; c < afu_pkg::NUM_CLASSES; c++) begin
			if (mask[c]) begin
				seq++;
				cmd_drive[c] <= make_line(c, seq);
			end else begin
				cmd_drive[c] <= '0;
			end
		end
	endtask

	task automatic wait_idle();
		repeat (2) @(posedge clock);
		@(negedge clock);
		while (queued.size() > 0 || pending.size() > 0 || tag_busy != '0 || expected.size() > 0) begin
			@(negedge clock);
		end
	endtask

	initial begin : watchdog
		repeat (NUM_CMDS * CYCLES_PER_CMD + 100) @(posedge clock);
		fail_with("Timeout: the commands did not all complete in the allowed time");
	end

	initial begin : stimulus
		int base;
		logic [afu_pkg::NUM_CLASSES-1:0] mask;
		logic [afu_pkg::NUM_CLASSES-1:0] last_mask;
		rst_n = 1'b0;
		enabled = 1'b0;
		cmd_drive = '0;
		hold_rsp = 1'b0;
		seq = 0;
		stim_rng = 32'd96481;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;

		// One line per class while disabled, a second restart fills its queue
		push_lines('1);
		push_lines(4'b0001);
		push_lines('0);
		repeat (6) @(posedge clock);
		assert (command_status.full == 4'b0001 && command_status.empty == '0)
			else fail_with($sformatf("FAIL %0t status %b with lines held", $time,
				command_status));
		base = issue_log.size();
		enabled <= 1'b1;
		wait_idle();
		// Both restarts first, then wed, write and read
		for (int c = 0; c <= afu_pkg::NUM_CLASSES; c++) begin
			assert (issue_log[base + c] == afu_pkg::cmd_class_t'((c == 0) ? 0 : c - 1))
				else fail_with($sformatf("FAIL %0t priority slot %0d", $time, c));
		end

		// Read burst in push order, then an isolated push
		repeat (5) push_lines(4'b1000);
		push_lines('0);
		wait_idle();
		push_lines(4'b1000);
		push_lines('0);
		@(negedge clock);
		assert (!host_cmd_out.valid) else fail_with($sformatf("FAIL %0t issue too early", $time));
		@(negedge clock);
		assert (host_cmd_out.valid) else fail_with($sformatf("FAIL %0t issue not at 2", $time));
		wait_idle();

		// Responses held back, issue stops at the credit limit
		hold_rsp = 1'b1;
		base = issue_log.size();
		repeat (6) push_lines(4'b1000);
		push_lines('0);
		while (issue_log.size() < base + afu_pkg::INIT_CREDITS) @(negedge clock);
		repeat (10) @(negedge clock);
		assert (issue_log.size() == base + afu_pkg::INIT_CREDITS)
			else fail_with($sformatf("FAIL %0t issued past credits", $time));
		hold_rsp = 1'b0;
		wait_idle();

		// Random mix, never two pushes in a row into one class
		last_mask = '0;
		repeat (40) begin
			@(negedge clock);
			stim_rng = xorshift(stim_rng);
			mask = stim_rng[3:0] & ~command_status.full & ~last_mask;
			push_lines(mask);
			last_mask = mask;
		end
		push_lines('0);
		wait_idle();

		// Every queue drained once all commands are out
		if (command_status.empty != '1 || command_status.full != '0) begin
			fail_with($sformatf("FAIL %0t queues not idle at the end, status %b", $time,
				command_status));
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- afu_control.sv
`default_nettype none

module afu_control (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic enabled,
	input wire afu_pkg::cmd_line_t restart_cmd_in,
	input wire afu_pkg::cmd_line_t wed_cmd_in,
	input wire afu_pkg::cmd_line_t write_cmd_in,
	input wire afu_pkg::cmd_line_t read_cmd_in,
	input wire afu_pkg::host_rsp_t host_rsp_in,
	output afu_pkg::host_cmd_t host_cmd_out,
	output afu_pkg::rsp_line_t restart_rsp_out,
	output afu_pkg::rsp_line_t wed_rsp_out,
	output afu_pkg::rsp_line_t write_rsp_out,
	output afu_pkg::rsp_line_t read_rsp_out,
	output afu_pkg::cmd_status_t command_status
);

	// Command side, indexed by class code
	afu_pkg::cmd_line_t [afu_pkg::NUM_CLASSES-1:0] cmd_in;
	afu_pkg::cmd_line_t [afu_pkg::NUM_CLASSES-1:0] heads;
	logic [afu_pkg::NUM_CLASSES-1:0] cmd_empty;
	logic [afu_pkg::NUM_CLASSES-1:0] cmd_full;
	logic [afu_pkg::NUM_CLASSES-1:0] grant;

	// Issue handshake between arbiter, credits and tags
	logic issue;
	afu_pkg::cmd_class_t issue_class;
	logic credit_ok;
	logic tag_ready;
	logic [afu_pkg::TAG_W-1:0] free_tag;

	// Response side
	logic [afu_pkg::TAG_W-1:0] lookup_tag;
	logic lookup_valid;
	afu_pkg::cmd_class_t lookup_class;
	logic signed [afu_pkg::CREDIT_W-1:0] rsp_credits;
	logic [afu_pkg::NUM_CLASSES-1:0] rsp_push;
	afu_pkg::rsp_line_t rsp_line;
	afu_pkg::rsp_line_t [afu_pkg::NUM_CLASSES-1:0] rsp_out;
	logic [afu_pkg::NUM_CLASSES-1:0] rsp_empty;

	assign cmd_in[afu_pkg::CLASS_RESTART] = restart_cmd_in;
	assign cmd_in[afu_pkg::CLASS_WED] = wed_cmd_in;
	assign cmd_in[afu_pkg::CLASS_WRITE] = write_cmd_in;
	assign cmd_in[afu_pkg::CLASS_READ] = read_cmd_in;
	assign command_status = '{empty: cmd_empty, full: cmd_full};

	assign restart_rsp_out = rsp_out[afu_pkg::CLASS_RESTART];
	assign wed_rsp_out = rsp_out[afu_pkg::CLASS_WED];
	assign write_rsp_out = rsp_out[afu_pkg::CLASS_WRITE];
	assign read_rsp_out = rsp_out[afu_pkg::CLASS_READ];

	////////////////////////////////////////
	// Class queues
	////////////////////////////////////////

	for (genvar g = 0; g < afu_pkg::NUM_CLASSES; g++) begin : g_class
		// Read and write get the deep command queues
		sync_fifo #(
			.payload_t(afu_pkg::cmd_line_t),
			.DEPTH((g == afu_pkg::CLASS_WRITE || g == afu_pkg::CLASS_READ) ?
				afu_pkg::CMD_DEPTH_BIG : afu_pkg::CMD_DEPTH_SMALL)
		) cmd_fifo (
			.clock(clock), .rst_n(rst_n),
			.push(cmd_in[g].valid), .data_in(cmd_in[g]),
			.pop(grant[g]), .data_out(heads[g]),
			.empty(cmd_empty[g]), .full(cmd_full[g])
		);

		// Drains itself one line per cycle
		sync_fifo #(
			.payload_t(afu_pkg::rsp_line_t),
			.DEPTH(afu_pkg::RSP_DEPTH)
		) rsp_fifo (
			.clock(clock), .rst_n(rst_n),
			.push(rsp_push[g]), .data_in(rsp_line),
			.pop(!rsp_empty[g]), .data_out(rsp_out[g]),
			.empty(rsp_empty[g]), .full()
		);
	end

	////////////////////////////////////////
	// Issue and response control
	////////////////////////////////////////

	command_arbiter arbiter (
		.clock(clock), .rst_n(rst_n), .enabled(enabled),
		.heads(heads), .empties(cmd_empty),
		.credit_ok(credit_ok), .tag_ready(tag_ready), .free_tag(free_tag),
		.grant(grant), .issue(issue), .issue_class(issue_class),
		.host_cmd_out(host_cmd_out)
	);

	credit_tracker credits (
		.clock(clock), .rst_n(rst_n), .issue(issue),
		.rsp_valid(lookup_valid), .rsp_credits(rsp_credits),
		.credit_ok(credit_ok)
	);

	tag_table tags (
		.clock(clock), .rst_n(rst_n),
		.issue(issue), .issue_class(issue_class),
		.tag_ready(tag_ready), .free_tag(free_tag),
		.rsp_valid(lookup_valid), .rsp_tag(lookup_tag), .rsp_class(lookup_class)
	);

	response_router router (
		.clock(clock), .rst_n(rst_n), .host_rsp_in(host_rsp_in),
		.lookup_tag(lookup_tag), .lookup_valid(lookup_valid),
		.lookup_class(lookup_class), .rsp_credits(rsp_credits),
		.push(rsp_push), .rsp_line(rsp_line)
	);

endmodule

`default_nettype wire

//--- response_router.sv
`default_nettype none

module response_router (
	input wire logic clock,
	input wire logic rst_n,
	input wire afu_pkg::host_rsp_t host_rsp_in,
	output logic [afu_pkg::TAG_W-1:0] lookup_tag,
	output logic lookup_valid,
	input wire afu_pkg::cmd_class_t lookup_class,
	output logic signed [afu_pkg::CREDIT_W-1:0] rsp_credits,
	output logic [afu_pkg::NUM_CLASSES-1:0] push,
	output afu_pkg::rsp_line_t rsp_line
);

	// Host response latch
	afu_pkg::host_rsp_t rsp_q;

	always_ff @(posedge clock) begin
		rsp_q.tag <= host_rsp_in.tag;
		rsp_q.response <= host_rsp_in.response;
		rsp_q.credits <= host_rsp_in.credits;
		if (!rst_n) begin
			rsp_q.valid <= 1'b0;
		end else begin
			rsp_q.valid <= host_rsp_in.valid;
		end
	end

	// Latched response drives lookup, tag free and credit return
	assign lookup_tag = rsp_q.tag;
	assign lookup_valid = rsp_q.valid;
	assign rsp_credits = rsp_q.credits;

	////////////////////////////////////////
	// Push into the owning class
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		rsp_line.rsp_class <= lookup_class;
		rsp_line.tag <= rsp_q.tag;
		rsp_line.response <= rsp_q.response;
		if (!rst_n) begin
			push <= '0;
			rsp_line.valid <= 1'b0;
		end else begin
			push <= '0;
			// Exactly one class gets the line
			if (rsp_q.valid) begin
				push[lookup_class] <= 1'b1;
			end
			rsp_line.valid <= rsp_q.valid;
		end
	end

endmodule

`default_nettype wire

//--- tag_table.sv
`default_nettype none

module tag_table (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic issue,
	input wire afu_pkg::cmd_class_t issue_class,
	output logic tag_ready,
	output logic [afu_pkg::TAG_W-1:0] free_tag,
	input wire logic rsp_valid,
	input wire logic [afu_pkg::TAG_W-1:0] rsp_tag,
	output afu_pkg::cmd_class_t rsp_class
);

	// Outstanding flag per tag
	logic [afu_pkg::NUM_TAGS-1:0] busy;
	// Owning class per tag, kept after free
	afu_pkg::cmd_class_t class_of [afu_pkg::NUM_TAGS];
	// Response tag is a known outstanding one
	logic rsp_hit;

	////////////////////////////////////////
	// Free tag search
	////////////////////////////////////////

	// Lowest free index wins
	always_comb begin
		tag_ready = 1'b0;
		free_tag = '0;
		for (int i = afu_pkg::NUM_TAGS - 1; i >= 0; i--) begin
			if (!busy[i]) begin
				tag_ready = 1'b1;
				free_tag = afu_pkg::TAG_W'(i);
			end
		end
	end

	// Class lookup for the response
	always_comb begin
		rsp_class = afu_pkg::CLASS_RESTART;
		rsp_hit = 1'b0;
		for (int i = 0; i < afu_pkg::NUM_TAGS; i++) begin
			if (rsp_tag == afu_pkg::TAG_W'(i)) begin
				rsp_class = class_of[i];
				rsp_hit = busy[i];
			end
		end
	end

	////////////////////////////////////////
	// Allocate and free
	////////////////////////////////////////

	// Issued tag is always free, so set and clear never collide
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			busy <= '0;
		end else begin
			for (int i = 0; i < afu_pkg::NUM_TAGS; i++) begin
				if (issue && free_tag == afu_pkg::TAG_W'(i)) begin
					busy[i] <= 1'b1;
				end else if (rsp_valid && rsp_tag == afu_pkg::TAG_W'(i)) begin
					busy[i] <= 1'b0;
				end
			end
		end
	end

	// Class table write on allocation
	always_ff @(posedge clock) begin
		for (int i = 0; i < afu_pkg::NUM_TAGS; i++) begin
			if (issue && free_tag == afu_pkg::TAG_W'(i)) begin
				class_of[i] <= issue_class;
			end
		end
	end

	// Host answers only tags it was given
	assert property (@(posedge clock) disable iff (!rst_n) rsp_valid |-> rsp_hit)
		else $fatal(1, "FAIL %0t response for idle tag %0d", $time, rsp_tag);

endmodule

`default_nettype wire

//--- credit_tracker.sv
`default_nettype none

module credit_tracker (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic issue,
	input wire logic rsp_valid,
	input wire logic signed [afu_pkg::CREDIT_W-1:0] rsp_credits,
	output logic credit_ok
);

	// Credits currently held
	logic signed [afu_pkg::CREDIT_W-1:0] count;
	// One per issued command
	logic signed [afu_pkg::CREDIT_W-1:0] spent;
	// Whatever the host hands back
	logic signed [afu_pkg::CREDIT_W-1:0] refill;

	assign spent = issue ? afu_pkg::CREDIT_W'(1) : '0;
	assign refill = rsp_valid ? rsp_credits : '0;

	// Spend and refill may land on the same edge
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			count <= afu_pkg::CREDIT_W'(afu_pkg::INIT_CREDITS);
		end else begin
			count <= count - spent + refill;
		end
	end

	assign credit_ok = (count > 0);

	// Host never returns more than it granted
	assert property (@(posedge clock) disable iff (!rst_n)
		count <= afu_pkg::INIT_CREDITS)
		else $fatal(1, "FAIL %0t credit count %0d above initial", $time, count);

endmodule

`default_nettype wire

//--- command_arbiter.sv
`default_nettype none

module command_arbiter (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic enabled,
	input wire afu_pkg::cmd_line_t [afu_pkg::NUM_CLASSES-1:0] heads,
	input wire logic [afu_pkg::NUM_CLASSES-1:0] empties,
	input wire logic credit_ok,
	input wire logic tag_ready,
	input wire logic [afu_pkg::TAG_W-1:0] free_tag,
	output logic [afu_pkg::NUM_CLASSES-1:0] grant,
	output logic issue,
	output afu_pkg::cmd_class_t issue_class,
	output afu_pkg::host_cmd_t host_cmd_out
);

	afu_pkg::cmd_line_t sel_head;

	// Fixed priority, lowest class code first
	// Walk downwards so the last hit is the winner
	always_comb begin
		grant = '0;
		issue_class = afu_pkg::CLASS_RESTART;
		sel_head = heads[0];
		if (enabled && credit_ok && tag_ready) begin
			for (int i = afu_pkg::NUM_CLASSES - 1; i >= 0; i--) begin
				if (!empties[i]) begin
					grant = '0;
					grant[i] = 1'b1;
					issue_class = afu_pkg::cmd_class_t'(i);
					sel_head = heads[i];
				end
			end
		end
	end

	// Credit and tag are spent on this same edge
	assign issue = |grant;

	////////////////////////////////////////
	// Registered issue to the host
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		host_cmd_out.tag <= free_tag;
		host_cmd_out.code <= sel_head.code;
		host_cmd_out.address <= sel_head.address;
		host_cmd_out.size <= sel_head.size;
		if (!rst_n) begin
			host_cmd_out.valid <= 1'b0;
		end else begin
			host_cmd_out.valid <= issue;
		end
	end

	// Single winner, and only ever a FIFO that holds a line
	assert property (@(posedge clock) disable iff (!rst_n)
		$onehot0(grant) && ((grant & empties) == '0))
		else $fatal(1, "FAIL %0t bad command grant %b", $time, grant);

endmodule

`default_nettype wire

//--- sync_fifo.sv
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic,
	parameter int DEPTH = 2
) (
	input wire logic clock,
	input wire logic rst_n,
	input wire logic push,
	input wire payload_t data_in,
	input wire logic pop,
	output payload_t data_out,
	output logic empty,
	output logic full
);

	// Storage and circular pointers
	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	// One extra bit so a full queue is distinct from an empty one
	logic [$clog2(DEPTH):0] count;

	// Payload write, no reset on storage
	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	// Pointer and occupancy update
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == $bits(wr_ptr)'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == $bits(rd_ptr)'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign empty = (count == '0);
	assign full = (count == $bits(count)'(DEPTH));
	// Head shown before the pop, zero when nothing is queued
	assign data_out = empty ? payload_t'('0) : mem[rd_ptr];

	// Sender honours full, consumer honours empty
	assert property (@(posedge clock) disable iff (!rst_n) push |-> !full)
		else $fatal(1, "FAIL %0t push into full FIFO", $time);
	assert property (@(posedge clock) disable iff (!rst_n) pop |-> !empty)
		else $fatal(1, "FAIL %0t pop from empty FIFO", $time);

endmodule

`default_nettype wire

//--- afu_pkg.sv
`default_nettype none

package afu_pkg;

	////////////////////////////////////////
	// Sizes and depths
	////////////////////////////////////////

	// Command classes
	localparam int NUM_CLASSES = 4;
	localparam int CLASS_W = 2;

	// Tags handed out to the host
	localparam int TAG_W = 8;
	localparam int NUM_TAGS = 8;

	// Signed credit count, host may return several at once
	localparam int CREDIT_W = 9;
	localparam int INIT_CREDITS = 4;

	// Queue depths
	localparam int CMD_DEPTH_BIG = 16;
	localparam int CMD_DEPTH_SMALL = 2;
	localparam int RSP_DEPTH = 16;

	// Command payload fields
	localparam int CODE_W = 8;
	localparam int ADDR_W = 64;
	localparam int SIZE_W = 12;

	////////////////////////////////////////
	// Types
	////////////////////////////////////////

	// Lower code wins arbitration
	typedef enum logic [CLASS_W-1:0] {
		CLASS_RESTART = 2'd0,
		CLASS_WED = 2'd1,
		CLASS_WRITE = 2'd2,
		CLASS_READ = 2'd3
	} cmd_class_t;

	// Queued by the compute side
	typedef struct packed {
		logic valid;
		logic [CODE_W-1:0] code;
		logic [ADDR_W-1:0] address;
		logic [SIZE_W-1:0] size;
	} cmd_line_t;

	// Issued to the host, tag attached
	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [CODE_W-1:0] code;
		logic [ADDR_W-1:0] address;
		logic [SIZE_W-1:0] size;
	} host_cmd_t;

	// Host response with credit return
	typedef struct packed {
		logic valid;
		logic [TAG_W-1:0] tag;
		logic [CODE_W-1:0] response;
		logic signed [CREDIT_W-1:0] credits;
	} host_rsp_t;

	// Response after routing to its class
	typedef struct packed {
		logic valid;
		cmd_class_t rsp_class;
		logic [TAG_W-1:0] tag;
		logic [CODE_W-1:0] response;
	} rsp_line_t;

	// Indexed by class code
	typedef struct packed {
		logic [NUM_CLASSES-1:0] empty;
		logic [NUM_CLASSES-1:0] full;
	} cmd_status_t;

endpackage

`default_nettype wire
